//--- Makefile
# Verilator build and run of the exec_core testbench

VERILATOR  ?= verilator
TOP        ?= exec_core_tb
FILELIST   ?= mips16_exec.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG   ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- mips16_exec.f
src/mips16_pkg.sv
src/reg_file.sv
src/decode_stage.sv
src/id_exe.sv
src/exe_alu.sv
src/exec_core.sv
tb/exec_core_tb.sv

//--- src/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   issue,
	input  mips16_pkg::opn_t       issue_opn,
	input  mips16_pkg::pc_t        issue_pc,
	input  mips16_pkg::dec_ctrl_t  idex_ctrl,
	input  logic                   idex_valid,
	input  mips16_pkg::reg_value_t rd_value1,
	input  mips16_pkg::reg_value_t rd_value2,
	output mips16_pkg::reg_addr_t  rd_addr1,
	output mips16_pkg::reg_addr_t  rd_addr2,
	output logic                   hold,
	output logic                   valid,
	output mips16_pkg::opn_t       opn,
	output mips16_pkg::pc_t        pc,
	output mips16_pkg::dec_ctrl_t  ctrl,
	output mips16_pkg::reg_value_t read_value1,
	output mips16_pkg::reg_value_t read_value2
);

	mips16_pkg::reg_addr_t rx;
	mips16_pkg::reg_addr_t ry;
	mips16_pkg::reg_addr_t rz;
	logic                  use1;     // Port 1 value is a real source
	logic                  use2;

	////////////////////////////////////////////////////////////
	// Instruction register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else if (!hold) begin
			valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold && issue) begin
			opn <= issue_opn;
			pc  <= issue_pc;
		end
	end

	assign rx = {1'b0, opn[10:8]};
	assign ry = {1'b0, opn[7:5]};
	assign rz = {1'b0, opn[4:2]};

	////////////////////////////////////////////////////////////
	// Field decode
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_addr1       = rx;
		rd_addr2       = ry;
		use1           = 1'b0;
		use2           = 1'b0;
		ctrl.reg_write = 1'b0;          // Anything unknown retires as NOP
		ctrl.reg_addr  = rx;
		ctrl.alu_op    = mips16_pkg::alu_pass;
		case (mips16_pkg::major_op_e'(opn[15:11]))
			mips16_pkg::maj_addiu: begin
				use1           = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = mips16_pkg::alu_add;
			end
			mips16_pkg::maj_addiu3: begin
				use1           = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.reg_addr  = ry;
				ctrl.alu_op    = mips16_pkg::alu_add;
			end
			mips16_pkg::maj_sp: begin
				if (opn[10:8] == 3'b011) begin      // ADDSP
					rd_addr1       = mips16_pkg::sp_index;
					use1           = 1'b1;
					ctrl.reg_write = 1'b1;
					ctrl.reg_addr  = mips16_pkg::sp_index;
					ctrl.alu_op    = mips16_pkg::alu_add;
				end else if ((opn[10:8] == 3'b100) && (opn[4:0] == 5'b00000)) begin
					// MTSP carries its source in bits 7 to 5
					rd_addr1       = ry;
					use1           = 1'b1;
					ctrl.reg_write = 1'b1;
					ctrl.reg_addr  = mips16_pkg::sp_index;
				end
			end
			mips16_pkg::maj_li: begin
				ctrl.reg_write = 1'b1;
			end
			mips16_pkg::maj_move: begin
				if (opn[4:0] == 5'b00000) begin
					use2           = 1'b1;
					ctrl.reg_write = 1'b1;
				end
			end
			mips16_pkg::maj_rrr: begin
				use1           = 1'b1;
				use2           = 1'b1;
				ctrl.reg_addr  = rz;
				ctrl.reg_write = opn[0];        // 01 ADDU and 11 SUBU
				ctrl.alu_op    = opn[1] ? mips16_pkg::alu_sub : mips16_pkg::alu_add;
			end
			mips16_pkg::maj_rr: begin
				case (opn[4:0])
					5'b01100: begin
						use1           = 1'b1;
						use2           = 1'b1;
						ctrl.reg_write = 1'b1;
						ctrl.alu_op    = mips16_pkg::alu_and;
					end
					5'b01101: begin
						use1           = 1'b1;
						use2           = 1'b1;
						ctrl.reg_write = 1'b1;
						ctrl.alu_op    = mips16_pkg::alu_or;
					end
					5'b01010: begin
						use1           = 1'b1;
						use2           = 1'b1;
						ctrl.reg_write = 1'b1;
						ctrl.reg_addr  = mips16_pkg::t_index;
						ctrl.alu_op    = mips16_pkg::alu_cmp;
					end
					5'b00111: begin         // Shift ry by rx
						rd_addr1       = ry;
						rd_addr2       = rx;
						use1           = 1'b1;
						use2           = 1'b1;
						ctrl.reg_write = 1'b1;
						ctrl.reg_addr  = ry;
						ctrl.alu_op    = mips16_pkg::alu_srav;
					end
					default: begin
						if (opn[7:0] == 8'b0100_0000) begin  // MFPC
							ctrl.reg_write = 1'b1;
							ctrl.alu_op    = mips16_pkg::alu_add;
						end
					end
				endcase
			end
			mips16_pkg::maj_ih: begin
				if (opn[7:0] == 8'h00) begin         // MFIH
					rd_addr1       = mips16_pkg::ih_index;
					use1           = 1'b1;
					ctrl.reg_write = 1'b1;
				end else if (opn[7:0] == 8'h01) begin  // MTIH
					use1           = 1'b1;
					ctrl.reg_write = 1'b1;
					ctrl.reg_addr  = mips16_pkg::ih_index;
				end
			end
			mips16_pkg::maj_shift: begin
				use2           = 1'b1;
				ctrl.reg_write = (opn[1:0] != 2'b01);
				case (opn[1:0])
					2'b00:   ctrl.alu_op = mips16_pkg::alu_sll;
					2'b10:   ctrl.alu_op = mips16_pkg::alu_srl;
					default: ctrl.alu_op = mips16_pkg::alu_sra;
				endcase
			end
			default: ;
		endcase
	end

	// Stall on a source still being produced in execute
	assign hold = valid && idex_valid && idex_ctrl.reg_write &&
		((use1 && (rd_addr1 == idex_ctrl.reg_addr)) ||
		 (use2 && (rd_addr2 == idex_ctrl.reg_addr)));

	assign read_value1 = rd_value1;
	assign read_value2 = rd_value2;

endmodule

//--- src/exe_alu.sv
`timescale 1ns/100ps

module exe_alu (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mips16_pkg::exe_pkt_t   pkt,
	output logic                   wr_en,
	output mips16_pkg::reg_addr_t  wr_addr,
	output mips16_pkg::reg_value_t wr_data
);

	mips16_pkg::reg_value_t result;
	mips16_pkg::reg_value_t sra_res;

	assign sra_res = mips16_pkg::reg_value_t'($signed(pkt.op1) >>> pkt.op2);

	////////////////////////////////////////////////////////////
	// Result select
	////////////////////////////////////////////////////////////

	always_comb begin
		case (pkt.ctrl.alu_op)
			mips16_pkg::alu_add:  result = pkt.op1 + pkt.op2;    // Wraps at 16 bits
			mips16_pkg::alu_sub:  result = pkt.op1 - pkt.op2;
			mips16_pkg::alu_and:  result = pkt.op1 & pkt.op2;
			mips16_pkg::alu_or:   result = pkt.op1 | pkt.op2;
			mips16_pkg::alu_cmp:  result = (pkt.op1 == pkt.op2) ? 16'd0 : 16'd1;
			mips16_pkg::alu_sll:  result = pkt.op1 << pkt.op2;
			mips16_pkg::alu_srl:  result = pkt.op1 >> pkt.op2;
			mips16_pkg::alu_sra,
			mips16_pkg::alu_srav: result = sra_res;             // SRAV amount from rx
			mips16_pkg::alu_pass: result = pkt.op1;
			default:              result = '0;
		endcase
	end

	assign wr_en   = pkt.valid && pkt.ctrl.reg_write;
	assign wr_addr = pkt.ctrl.reg_addr;
	assign wr_data = result;

endmodule

//--- src/exec_core.sv
`timescale 1ns/100ps

module exec_core (
	input  logic                 clk,
	input  logic                 rst_n,
	input  mips16_pkg::wb_req_t  wb_req,
	output mips16_pkg::wb_rsp_t  wb_rsp
);

	typedef enum logic {
		wb_idle,
		wb_done                     // Acked and waiting for stb to drop
	} wb_state_e;

	wb_state_e              wb_state;
	logic                   ack_q;
	mips16_pkg::reg_value_t rsp_dat_q;
	mips16_pkg::pc_t        issue_cnt;

	mips16_pkg::reg_addr_t  rd_addr1;
	mips16_pkg::reg_addr_t  rd_addr2;
	mips16_pkg::reg_value_t rd_value1;
	mips16_pkg::reg_value_t rd_value2;
	mips16_pkg::reg_addr_t  dbg_addr;
	mips16_pkg::reg_value_t dbg_value;
	logic                   wr_en;
	mips16_pkg::reg_addr_t  wr_addr;
	mips16_pkg::reg_value_t wr_data;

	logic                   dec_hold;
	logic                   dec_valid;
	mips16_pkg::opn_t       dec_opn;
	mips16_pkg::pc_t        dec_pc;
	mips16_pkg::dec_ctrl_t  dec_ctrl;
	mips16_pkg::reg_value_t dec_value1;
	mips16_pkg::reg_value_t dec_value2;
	mips16_pkg::exe_pkt_t   exe_pkt;

	logic req_live;
	logic is_issue;
	logic in_window;
	logic pipe_empty;
	logic accept;
	logic issue;
	logic flush;

	////////////////////////////////////////////////////////////
	// Wishbone slave
	////////////////////////////////////////////////////////////

	assign req_live   = (wb_state == wb_idle) && wb_req.cyc && wb_req.stb;
	assign is_issue   = wb_req.we && (wb_req.adr == mips16_pkg::wb_issue_adr);
	assign dbg_addr   = wb_req.adr - mips16_pkg::wb_reg_base;
	assign in_window  = (wb_req.adr >= mips16_pkg::wb_reg_base) &&
		(dbg_addr <= mips16_pkg::t_index);
	assign pipe_empty = !dec_valid && !exe_pkt.valid;
	assign accept     = req_live && (is_issue ? !dec_hold : (wb_req.we || pipe_empty));
	assign issue      = req_live && is_issue && !dec_hold;
	assign flush      = dec_hold;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_state  <= wb_idle;
			ack_q     <= 1'b0;
			issue_cnt <= '0;
		end else begin
			ack_q <= accept;                // One cycle pulse
			case (wb_state)
				wb_idle: if (accept) wb_state <= wb_done;
				wb_done: if (!wb_req.stb) wb_state <= wb_idle;
				default: wb_state <= wb_idle;
			endcase
			if (issue) begin
				issue_cnt <= issue_cnt + 16'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !wb_req.we) begin
			rsp_dat_q <= in_window ? dbg_value : '0;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rsp_dat_q;

	////////////////////////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////////////////////////

	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr1  (rd_addr1),
		.rd_addr2  (rd_addr2),
		.dbg_addr  (dbg_addr),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_value1 (rd_value1),
		.rd_value2 (rd_value2),
		.dbg_value (dbg_value)
	);

	decode_stage u_decode_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue       (issue),
		.issue_opn   (wb_req.dat),
		.issue_pc    (issue_cnt),
		.idex_ctrl   (exe_pkt.ctrl),
		.idex_valid  (exe_pkt.valid),
		.rd_value1   (rd_value1),
		.rd_value2   (rd_value2),
		.rd_addr1    (rd_addr1),
		.rd_addr2    (rd_addr2),
		.hold        (dec_hold),
		.valid       (dec_valid),
		.opn         (dec_opn),
		.pc          (dec_pc),
		.ctrl        (dec_ctrl),
		.read_value1 (dec_value1),
		.read_value2 (dec_value2)
	);

	id_exe u_id_exe (
		.clk         (clk),
		.rst_n       (rst_n),
		.hold        (dec_hold),
		.flush       (flush),
		.valid       (dec_valid),
		.ctrl        (dec_ctrl),
		.opn         (dec_opn),
		.pc          (dec_pc),
		.read_value1 (dec_value1),
		.read_value2 (dec_value2),
		.pkt         (exe_pkt)
	);

	exe_alu u_exe_alu (
		.clk     (clk),
		.rst_n   (rst_n),
		.pkt     (exe_pkt),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

endmodule

//--- src/id_exe.sv
`timescale 1ns/100ps

module id_exe (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   hold,
	input  logic                   flush,
	input  logic                   valid,
	input  mips16_pkg::dec_ctrl_t  ctrl,
	input  mips16_pkg::opn_t       opn,
	input  mips16_pkg::pc_t        pc,
	input  mips16_pkg::reg_value_t read_value1,
	input  mips16_pkg::reg_value_t read_value2,
	output mips16_pkg::exe_pkt_t   pkt
);

	mips16_pkg::reg_value_t op1_next;
	mips16_pkg::reg_value_t op2_next;
	mips16_pkg::reg_value_t imm8_sext;
	mips16_pkg::reg_value_t imm8_zext;
	mips16_pkg::reg_value_t imm4_sext;
	mips16_pkg::reg_value_t shamt;

	assign imm8_sext = {{8{opn[7]}}, opn[7:0]};
	assign imm8_zext = {8'b0, opn[7:0]};
	assign imm4_sext = {{12{opn[3]}}, opn[3:0]};
	assign shamt     = (opn[4:2] == 3'b000) ? 16'd8 : {13'b0, opn[4:2]};  // Zero means 8

	////////////////////////////////////////////////////////////
	// Operand selection
	////////////////////////////////////////////////////////////

	always_comb begin
		op1_next = '0;
		op2_next = '0;
		case (mips16_pkg::major_op_e'(opn[15:11]))
			mips16_pkg::maj_addiu: begin
				op1_next = read_value1;
				op2_next = imm8_sext;
			end
			mips16_pkg::maj_addiu3: begin
				op1_next = read_value1;
				op2_next = imm4_sext;
			end
			mips16_pkg::maj_sp: begin         // ADDSP and MTSP
				op1_next = read_value1;
				op2_next = imm8_sext;
			end
			mips16_pkg::maj_li: begin
				op1_next = imm8_zext;
			end
			mips16_pkg::maj_move: begin
				op1_next = read_value2;
			end
			mips16_pkg::maj_rrr: begin
				op1_next = read_value1;
				op2_next = read_value2;
			end
			mips16_pkg::maj_rr: begin
				if (opn[7:0] == 8'b0100_0000) begin  // MFPC returns pc plus one
					op1_next = pc;
					op2_next = 16'd1;
				end else begin
					op1_next = read_value1;
					op2_next = read_value2;
				end
			end
			mips16_pkg::maj_ih: begin
				op1_next = read_value1;
			end
			mips16_pkg::maj_shift: begin
				op1_next = read_value2;
				op2_next = shamt;
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pkt.valid <= 1'b0;
		end else if (flush) begin
			pkt.valid <= 1'b0;          // Bubble behind a stalled decode
		end else if (!hold) begin
			pkt.valid <= valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			pkt.ctrl <= ctrl;
			pkt.op1  <= op1_next;
			pkt.op2  <= op2_next;
		end
	end

endmodule

//--- src/mips16_pkg.sv
package mips16_pkg;

	////////////////////////////////////////////////////////////
	// Datapath widths and register map
	////////////////////////////////////////////////////////////

	localparam int data_w    = 16;        // Register and datapath width
	localparam int reg_count = 11;        // General registers plus SP IH T

	typedef logic [data_w-1:0] reg_value_t;
	typedef logic [3:0]        reg_addr_t;
	typedef logic [15:0]       opn_t;
	typedef logic [data_w-1:0] pc_t;
	typedef logic [3:0]        wb_adr_t;

	localparam reg_addr_t sp_index = 4'd8;
	localparam reg_addr_t ih_index = 4'd9;
	localparam reg_addr_t t_index  = 4'd10;   // Highest valid register

	localparam wb_adr_t wb_issue_adr = 4'd0;  // Instruction issue port
	localparam wb_adr_t wb_reg_base  = 4'd1;  // Register n sits at base plus n

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////

	// Top five bits of the instruction word
	typedef enum logic [4:0] {
		maj_nop    = 5'b00001,
		maj_shift  = 5'b00110,   // SLL SRL SRA
		maj_addiu3 = 5'b01000,
		maj_addiu  = 5'b01001,
		maj_sp     = 5'b01100,   // ADDSP MTSP and BTEQZ
		maj_li     = 5'b01101,
		maj_move   = 5'b01111,
		maj_rrr    = 5'b11100,   // ADDU SUBU
		maj_rr     = 5'b11101,   // AND OR CMP SRAV MFPC and jumps
		maj_ih     = 5'b11110    // MFIH MTIH
	} major_op_e;

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_cmp  = 4'd4,
		alu_sll  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_srav = 4'd8,
		alu_pass = 4'd9
	} alu_op_e;

	////////////////////////////////////////////////////////////
	// Pipeline and bus packets
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic      reg_write;
		reg_addr_t reg_addr;
		alu_op_e   alu_op;
	} dec_ctrl_t;

	typedef struct packed {
		logic       valid;
		dec_ctrl_t  ctrl;
		reg_value_t op1;
		reg_value_t op2;
	} exe_pkt_t;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		wb_adr_t    adr;
		reg_value_t dat;
	} wb_req_t;

	typedef struct packed {
		logic       ack;
		reg_value_t dat;
	} wb_rsp_t;

endpackage

//--- src/reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mips16_pkg::reg_addr_t  rd_addr1,
	input  mips16_pkg::reg_addr_t  rd_addr2,
	input  mips16_pkg::reg_addr_t  dbg_addr,
	input  logic                   wr_en,
	input  mips16_pkg::reg_addr_t  wr_addr,
	input  mips16_pkg::reg_value_t wr_data,
	output mips16_pkg::reg_value_t rd_value1,
	output mips16_pkg::reg_value_t rd_value2,
	output mips16_pkg::reg_value_t dbg_value
);

	mips16_pkg::reg_value_t regs [mips16_pkg::reg_count];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < mips16_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr <= mips16_pkg::t_index)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Unmapped indices read as zero
	assign rd_value1 = (rd_addr1 <= mips16_pkg::t_index) ? regs[rd_addr1] : '0;
	assign rd_value2 = (rd_addr2 <= mips16_pkg::t_index) ? regs[rd_addr2] : '0;
	assign dbg_value = (dbg_addr <= mips16_pkg::t_index) ? regs[dbg_addr] : '0;

endmodule

//--- tb/exec_core_tb.sv
`timescale 1ns/100ps

module exec_core_tb;

	localparam int n_imm   = 24;     // Random immediate ops
	localparam int n_rr    = 40;     // Random register ops
	localparam int n_shift = 16;     // Random shift ops
	localparam int n_dumps = 12;     // Full register window reads
	// Issue costs about 3 cycles and a read about 4
	localparam int est_cycles = (n_imm + n_rr + n_shift + 40) * 3 + (n_dumps * 11 + 12) * 4 + 20;
	localparam int max_cycles = 4 * est_cycles;

	typedef enum {
		k_li, k_addiu, k_addiu3, k_addsp, k_mtsp,
		k_addu, k_subu, k_and, k_or, k_cmp, k_move,
		k_sll, k_srl, k_sra, k_srav,
		k_mfpc, k_mfih, k_mtih, k_nop, k_branch, k_jr
	} op_kind_e;

	logic                   clk;
	logic                   rst_n;
	mips16_pkg::wb_req_t    wb_req;
	mips16_pkg::wb_rsp_t    wb_rsp;

	mips16_pkg::reg_value_t model_regs [16];   // Only 0 to 10 are real
	mips16_pkg::pc_t        issue_count;
	logic [31:0]            lcg_state;
	int                     value_errors;
	int                     proto_errors;
	int                     req_count;
	int                     ack_count;
	int                     cycle_count;

	logic                   chk_read;         // Read in flight with a known answer
	mips16_pkg::reg_value_t exp_dat;
	mips16_pkg::wb_adr_t    exp_adr;

	op_kind_e imm_ops   [5] = '{k_li, k_addiu, k_addiu3, k_addsp, k_mtsp};
	op_kind_e rr_ops    [6] = '{k_addu, k_subu, k_and, k_or, k_cmp, k_move};
	op_kind_e shift_ops [4] = '{k_sll, k_srl, k_sra, k_srav};

	initial clk = 1'b0;
	always #20 clk = ~clk;

	exec_core u_exec_core (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	////////////////////////////////////////////////////////////
	// Checks on the bus
	////////////////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!rst_n)
		(wb_rsp.ack && chk_read) |-> (wb_rsp.dat == exp_dat))
	else begin
		value_errors++;
		$display("FAILED at %0t: address %0d (register %0d) read %h, expected %h",
			$time, exp_adr, int'(exp_adr) - 1, wb_rsp.dat, exp_dat);
	end

	assert property (@(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack)
	else begin
		proto_errors++;
		$display("At %0t the ack stayed high for more than one cycle", $time);
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
	else begin
		proto_errors++;
		$display("At %0t an ack came with no request on the bus", $time);
	end

	always @(posedge clk) begin
		if (rst_n && wb_rsp.ack) begin
			ack_count <= ack_count + 1;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", max_cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int pick(input int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[30:16]) % n;
	endfunction

	function automatic mips16_pkg::reg_addr_t gpr(input logic [2:0] f);
		return {1'b0, f};
	endfunction

	function automatic mips16_pkg::reg_value_t shift_right_arith(
		input mips16_pkg::reg_value_t v, input int n);
		mips16_pkg::reg_value_t res;
		res = v;
		for (int i = 0; i < n && i < 16; i++) begin
			res = {res[15], res[15:1]};    // Sign bit refills the top
		end
		return res;
	endfunction

	task automatic rand_fields(output logic [2:0] rx, output logic [2:0] ry,
		output logic [2:0] rz, output logic [7:0] imm);
		logic [31:0] r;
		r   = lcg_next();
		rx  = r[30:28];
		ry  = r[27:25];
		rz  = r[24:22];
		imm = r[21:14];
	endtask

	// One classic cycle, held until ack
	task automatic wb_cycle(input logic we, input mips16_pkg::wb_adr_t adr,
		input mips16_pkg::reg_value_t dat);
		mips16_pkg::wb_req_t req;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we  = we;
		req.adr = adr;
		req.dat = dat;
		@(posedge clk);
		wb_req <= req;
		req_count++;
		@(posedge clk);
		while (!wb_rsp.ack) begin
			@(posedge clk);
		end
		wb_req.cyc <= 1'b0;
		wb_req.stb <= 1'b0;
		wb_req.we  <= 1'b0;
	endtask

	task automatic wb_read(input mips16_pkg::wb_adr_t adr, input mips16_pkg::reg_value_t expected);
		exp_dat  <= expected;
		exp_adr  <= adr;
		chk_read <= 1'b1;
		wb_cycle(1'b0, adr, 16'h0000);
		chk_read <= 1'b0;
	endtask

	task automatic check_all_regs();
		mips16_pkg::reg_addr_t idx;
		for (int i = 0; i < mips16_pkg::reg_count; i++) begin
			idx = mips16_pkg::reg_addr_t'(i);
			wb_read(idx + mips16_pkg::wb_reg_base, model_regs[idx]);
		end
	endtask

	// Encode, update the model, then issue
	task automatic run_op(input op_kind_e kind, input logic [2:0] rx, input logic [2:0] ry,
		input logic [2:0] rz, input logic [7:0] imm);
		mips16_pkg::opn_t       opn;
		mips16_pkg::reg_value_t a;
		mips16_pkg::reg_value_t b;
		int                     amount;
		a      = model_regs[gpr(rx)];
		b      = model_regs[gpr(ry)];
		amount = (rz == 3'd0) ? 8 : int'(rz);   // Shift field sits in the rz slot
		case (kind)
			k_li: begin
				opn = {5'b01101, rx, imm};
				model_regs[gpr(rx)] = {8'h00, imm};
			end
			k_addiu: begin
				opn = {5'b01001, rx, imm};
				model_regs[gpr(rx)] = a + {{8{imm[7]}}, imm};
			end
			k_addiu3: begin
				opn = {5'b01000, rx, ry, 1'b0, imm[3:0]};
				model_regs[gpr(ry)] = a + {{12{imm[3]}}, imm[3:0]};
			end
			k_addsp: begin
				opn = {5'b01100, 3'b011, imm};
				model_regs[mips16_pkg::sp_index] = model_regs[mips16_pkg::sp_index] +
					{{8{imm[7]}}, imm};
			end
			k_mtsp: begin
				opn = {5'b01100, 3'b100, ry, 5'b00000};
				model_regs[mips16_pkg::sp_index] = b;
			end
			k_addu: begin
				opn = {5'b11100, rx, ry, rz, 2'b01};
				model_regs[gpr(rz)] = a + b;
			end
			k_subu: begin
				opn = {5'b11100, rx, ry, rz, 2'b11};
				model_regs[gpr(rz)] = a - b;
			end
			k_and: begin
				opn = {5'b11101, rx, ry, 5'b01100};
				model_regs[gpr(rx)] = a & b;
			end
			k_or: begin
				opn = {5'b11101, rx, ry, 5'b01101};
				model_regs[gpr(rx)] = a | b;
			end
			k_cmp: begin
				opn = {5'b11101, rx, ry, 5'b01010};
				model_regs[mips16_pkg::t_index] = (a == b) ? 16'd0 : 16'd1;
			end
			k_move: begin
				opn = {5'b01111, rx, ry, 5'b00000};
				model_regs[gpr(rx)] = b;
			end
			k_sll: begin
				opn = {5'b00110, rx, ry, rz, 2'b00};
				model_regs[gpr(rx)] = b << amount;
			end
			k_srl: begin
				opn = {5'b00110, rx, ry, rz, 2'b10};
				model_regs[gpr(rx)] = b >> amount;
			end
			k_sra: begin
				opn = {5'b00110, rx, ry, rz, 2'b11};
				model_regs[gpr(rx)] = shift_right_arith(b, amount);
			end
			k_srav: begin
				opn = {5'b11101, rx, ry, 5'b00111};   // ry shifted by the value of rx
				model_regs[gpr(ry)] = shift_right_arith(b, int'(a));
			end
			k_mfpc: begin
				opn = {5'b11101, rx, 8'b0100_0000};
				model_regs[gpr(rx)] = issue_count + 16'd1;
			end
			k_mfih: begin
				opn = {5'b11110, rx, 8'h00};
				model_regs[gpr(rx)] = model_regs[mips16_pkg::ih_index];
			end
			k_mtih: begin
				opn = {5'b11110, rx, 8'h01};
				model_regs[mips16_pkg::ih_index] = a;
			end
			k_branch: opn = {5'b00010, rx, imm};     // B, retires as NOP
			k_jr:     opn = {5'b11101, rx, 8'h00};   // JR, retires as NOP
			default:  opn = 16'h0800;
		endcase
		wb_cycle(1'b1, mips16_pkg::wb_issue_adr, opn);
		issue_count = issue_count + 16'd1;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [2:0] rx;
		logic [2:0] ry;
		logic [2:0] rz;
		logic [7:0] imm;
		rst_n        = 1'b0;
		wb_req       = '0;
		chk_read     = 1'b0;
		exp_dat      = '0;
		exp_adr      = '0;
		issue_count  = '0;
		lcg_state    = 32'h60b5_98c0;
		value_errors = 0;
		proto_errors = 0;
		req_count    = 0;
		ack_count    = 0;
		cycle_count  = 0;
		for (int i = 0; i < 16; i++) begin
			model_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// Idle bus, then everything reads zero
		repeat (10) @(posedge clk);
		check_all_regs();
		wb_read(mips16_pkg::wb_issue_adr, 16'h0000);
		for (int i = 12; i < 16; i++) begin
			wb_read(mips16_pkg::wb_adr_t'(i), 16'h0000);
		end

		// Immediates with the negative corners first
		run_op(k_li, 3'd1, 3'd0, 3'd0, 8'h80);       // Zero extended
		run_op(k_addiu, 3'd1, 3'd0, 3'd0, 8'hff);
		run_op(k_addiu3, 3'd1, 3'd2, 3'd0, 8'h08);   // imm4 of minus 8
		run_op(k_mtsp, 3'd0, 3'd1, 3'd0, 8'h00);
		run_op(k_addsp, 3'd0, 3'd0, 3'd0, 8'h80);
		check_all_regs();
		for (int i = 0; i < n_imm; i++) begin
			rand_fields(rx, ry, rz, imm);
			run_op(imm_ops[pick(5)], rx, ry, rz, imm);
			if (i % 6 == 5) begin
				check_all_regs();
			end
		end

		// Register to register ops issued back to back
		for (int i = 0; i < 8; i++) begin
			rand_fields(rx, ry, rz, imm);
			run_op(k_li, 3'(i), ry, rz, imm);
			run_op(k_addiu, 3'(i), ry, rz, {imm[0], imm[7:1]});
		end
		run_op(k_move, 3'd3, 3'd4, 3'd0, 8'h00);
		run_op(k_cmp, 3'd3, 3'd4, 3'd0, 8'h00);     // Equal operands
		for (int i = 0; i < n_rr; i++) begin
			rand_fields(rx, ry, rz, imm);
			run_op(rr_ops[pick(6)], rx, ry, rz, imm);
			if (i % 20 == 19) begin
				check_all_regs();
			end
		end

		// Shifts, field of zero means eight
		run_op(k_li, 3'd5, 3'd0, 3'd0, 8'h81);
		run_op(k_sll, 3'd6, 3'd5, 3'd0, 8'h00);
		run_op(k_sra, 3'd7, 3'd6, 3'd0, 8'h00);
		run_op(k_srl, 3'd2, 3'd6, 3'd3, 8'h00);
		run_op(k_li, 3'd1, 3'd0, 3'd0, 8'h03);
		run_op(k_srav, 3'd1, 3'd6, 3'd0, 8'h00);
		check_all_regs();
		for (int i = 0; i < n_shift; i++) begin
			rand_fields(rx, ry, rz, imm);
			run_op(shift_ops[pick(4)], rx, ry, rz, imm);
		end
		check_all_regs();

		// IH round trip and issue index
		rand_fields(rx, ry, rz, imm);
		run_op(k_li, 3'd2, 3'd0, 3'd0, imm);
		run_op(k_mtih, 3'd2, 3'd0, 3'd0, 8'h00);
		run_op(k_li, 3'd2, 3'd0, 3'd0, 8'h00);
		run_op(k_mfih, 3'd3, 3'd0, 3'd0, 8'h00);
		run_op(k_mfpc, 3'd4, 3'd0, 3'd0, 8'h00);
		run_op(k_nop, 3'd0, 3'd0, 3'd0, 8'h00);
		run_op(k_mfpc, 3'd5, 3'd0, 3'd0, 8'h00);
		check_all_regs();

		// Nothing here may touch a register
		run_op(k_nop, 3'd0, 3'd0, 3'd0, 8'h00);
		run_op(k_branch, 3'd6, 3'd0, 3'd0, 8'h5a);
		run_op(k_jr, 3'd7, 3'd0, 3'd0, 8'h00);
		wb_cycle(1'b1, 4'd1, 16'hdead);
		wb_cycle(1'b1, 4'd5, 16'hbeef);
		wb_cycle(1'b1, 4'd11, 16'h1234);
		wb_cycle(1'b1, 4'd15, 16'hffff);
		check_all_regs();

		repeat (4) @(posedge clk);
		assert (ack_count == req_count)
		else begin
			proto_errors++;
			$display("Saw %0d acks for %0d requests", ack_count, req_count);
		end
		$display("Done: %0d value errors, %0d protocol errors", value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
